// ==== tb/testdata_flight.txt ====
# name burst thr_us roll_us pitch_us yaw_us roll_ang pitch_ang roll_gyro pitch_gyro yaw_gyro m1 m2 m3 m4
# burst 1 strobes the IMU on the cycle after the line above and keeps its sticks
hover 0 1402 1502 1502 1502 0 0 0 0 0 100 100 100 100
roll_corr 0 1482 1542 1502 1502 20 0 30 0 0 111 129 129 111
pitch_corr 0 1602 1502 1402 1502 0 -40 -6 12 0 149 147 151 153
combined 0 1522 1442 1562 1502 -100 250 -200 40 18 155 25 115 225
yaw_clamp_hi 0 1922 1502 1502 2002 0 0 0 0 -300 124 250 124 250
yaw_clamp_lo 0 1242 1502 1502 1002 0 0 0 0 200 142 0 142 0
disarm 0 1036 1602 1502 1502 0 0 0 0 0 0 0 0 0
arm_edge 0 1040 1502 1502 1502 0 0 0 0 0 10 10 10 10
clamp_low 0 1402 900 1502 1502 0 0 0 0 0 84 116 116 84
clamp_high 0 1402 1502 2600 1502 0 0 0 0 0 115 115 85 85
glitch 0 3500 3400 1502 1502 0 0 0 0 0 100 100 100 100
burst_a 0 1562 1502 1502 1502 0 0 0 0 0 140 140 140 140
burst_b 1 1562 1502 1502 1502 8 0 0 0 0 139 141 141 139
burst_c 1 1562 1502 1502 1502 0 0 0 0 40 150 130 150 130

// ==== sim.f ====
common/flight_pkg.sv
common/rc_pkg.sv
hw/rc_pulse_decoder.sv
control/attitude_controller.sv
hw/motor_mixer.sv
hw/esc_pwm_generator.sv
hw/drone_core.sv
tb/drone_core_properties.sv
tb/tb_drone_core.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_drone_core
SRC := $(shell grep -v '^+' sim.f)

.PHONY: all run clean

all: run

$(SIM): $(SRC) sim.f
	verilator --binary --timing --assert -f sim.f --top-module tb_drone_core -o Vtb_drone_core

run: $(SIM) tb/testdata_flight.txt
	-./$(SIM) +verilator+error+limit+10 > sim.log 2>&1
	cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/tb_drone_core.sv ====
// Runs from the project root to find tb/testdata_flight.txt; every RC pulse costs milliseconds of sim time
`timescale 1ns/1ns

module tb_drone_core;
	import flight_pkg::*;
	import rc_pkg::*;

	localparam int CLK_NS    = 4;
	localparam int MAX_TESTS = 32;

	logic        sys_clk = 1'b0;
	logic        resetn;
	// Throttle, roll, pitch, yaw
	logic [3:0]  rc_pwm;
	logic        imu_valid;
	imu_sample_t roll_angle;
	imu_sample_t pitch_angle;
	imu_sample_t roll_gyro;
	imu_sample_t pitch_gyro;
	imu_sample_t yaw_gyro;
	logic        motor_1_pwm;
	logic        motor_2_pwm;
	logic        motor_3_pwm;
	logic        motor_4_pwm;
	logic        mix_valid;
	motor_rate_t motor_1_rate;
	motor_rate_t motor_2_rate;
	motor_rate_t motor_3_rate;
	motor_rate_t motor_4_rate;
	motor_rate_t rate_out [4];
	logic [3:0]  esc_pins;

	string  names [MAX_TESTS];
	int     burst [MAX_TESTS];
	int     pulse_us [MAX_TESTS][4];
	int     imu [MAX_TESTS][5];
	int     exp_rate [MAX_TESTS][4];
	int     n_tests;
	longint limit_ns = 0;

	assign rate_out[0] = motor_1_rate;
	assign rate_out[1] = motor_2_rate;
	assign rate_out[2] = motor_3_rate;
	assign rate_out[3] = motor_4_rate;
	assign esc_pins    = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};

	drone_core u_dut (
		.sys_clk(sys_clk), .resetn(resetn),
		.throttle_pwm(rc_pwm[0]), .roll_pwm(rc_pwm[1]),
		.pitch_pwm(rc_pwm[2]), .yaw_pwm(rc_pwm[3]), .imu_valid(imu_valid),
		.roll_angle(roll_angle), .pitch_angle(pitch_angle),
		.roll_gyro(roll_gyro), .pitch_gyro(pitch_gyro), .yaw_gyro(yaw_gyro),
		.motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm), .mix_valid(mix_valid),
		.motor_1_rate(motor_1_rate), .motor_2_rate(motor_2_rate),
		.motor_3_rate(motor_3_rate), .motor_4_rate(motor_4_rate));

	bind drone_core drone_core_properties u_props (
		.sys_clk(sys_clk), .resetn(resetn), .imu_valid(imu_valid), .mix_valid(mix_valid),
		.motor_1_rate(motor_1_rate), .motor_2_rate(motor_2_rate),
		.motor_3_rate(motor_3_rate), .motor_4_rate(motor_4_rate),
		.motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm));

	always #(CLK_NS / 2) sys_clk = ~sys_clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_motor_rate(input string tname, input int motor,
		input motor_rate_t exp, input motor_rate_t act);
		if (act !== exp)
			abort_run($sformatf("Mismatch %s motor_%0d_rate expected %0d actual %0d",
				tname, motor, exp, act));
	endtask

	// ESC high time, one tick of slack for the tick phase
	task automatic check_pulse_us(input string tname, input int motor, input int exp, input int act);
		if (act < exp - 1 || act > exp + 1)
			abort_run($sformatf("Mismatch %s motor_%0d_pwm us expected %0d actual %0d",
				tname, motor, exp, act));
	endtask

	task automatic check_latency(input string tname, input int exp, input int act);
		if (act != exp)
			abort_run($sformatf("Mismatch %s mix_valid latency expected %0d actual %0d",
				tname, exp, act));
	endtask

	task automatic load_tests();
		int    fd;
		int    cnt;
		int    widest;
		string line;
		string tname;
		int    v [14];
		fd = $fopen("tb/testdata_flight.txt", "r");
		if (fd == 0)
			abort_run("Could not open tb/testdata_flight.txt");
		n_tests = 0;
		while (n_tests < MAX_TESTS && $fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			cnt = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d", tname,
				v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
				v[10], v[11], v[12], v[13]);
			if (cnt != 15)
				abort_run($sformatf("Malformed test line: %s", line));
			names[n_tests] = tname;
			burst[n_tests] = v[0];
			widest = 0;
			for (int c = 0; c < 4; c++) begin
				pulse_us[n_tests][c] = v[1 + c];
				exp_rate[n_tests][c] = v[10 + c];
				if (v[1 + c] > widest)
					widest = v[1 + c];
			end
			for (int c = 0; c < 5; c++)
				imu[n_tests][c] = v[5 + c];
			// Pulses plus up to three ESC frames per line
			limit_ns += longint'(widest + 3 * ESC_PERIOD_US) * US_DIV * CLK_NS;
			n_tests++;
		end
		$fclose(fd);
		// Reset and slack
		limit_ns += longint'(2 * ESC_PERIOD_US) * US_DIV * CLK_NS;
	endtask

	// All four channels rise together, each falls after its own width
	task automatic send_rc_pulses(input int t);
		int         hi_cyc [4];
		int         max_cyc;
		logic [3:0] lvl;
		max_cyc = 0;
		for (int c = 0; c < 4; c++) begin
			hi_cyc[c] = pulse_us[t][c] * US_DIV;
			if (hi_cyc[c] > max_cyc)
				max_cyc = hi_cyc[c];
		end
		for (int n = 0; n <= max_cyc; n++) begin
			@(posedge sys_clk);
			for (int c = 0; c < 4; c++)
				lvl[c] = n < hi_cyc[c];
			rc_pwm <= lvl;
		end
		// Synchronizer, edge detect and value register
		repeat (6) @(posedge sys_clk);
	endtask

	// Strobes lines first..last on consecutive cycles and checks each result in order
	task automatic run_imu_group(input int first, input int last);
		int got;
		int cyc;
		@(negedge sys_clk);
		fork
			begin
				for (int k = first; k <= last; k++) begin
					@(posedge sys_clk);
					imu_valid   <= 1'b1;
					roll_angle  <= imu_sample_t'(imu[k][0]);
					pitch_angle <= imu_sample_t'(imu[k][1]);
					roll_gyro   <= imu_sample_t'(imu[k][2]);
					pitch_gyro  <= imu_sample_t'(imu[k][3]);
					yaw_gyro    <= imu_sample_t'(imu[k][4]);
				end
				@(posedge sys_clk);
				imu_valid <= 1'b0;
			end
			begin
				got = first;
				cyc = 0;
				while (got <= last) begin
					@(negedge sys_clk);
					cyc++;
					if (mix_valid) begin
						check_latency(names[got], 3, cyc - 1 - (got - first));
						for (int c = 0; c < 4; c++)
							check_motor_rate(names[got], c + 1, motor_rate_t'(exp_rate[got][c]),
								rate_out[c]);
						got++;
					end else if (cyc > last - first + 16) begin
						abort_run($sformatf("No mix_valid seen for test %s", names[got]));
					end
				end
			end
		join
	endtask

	task automatic wait_esc_rise();
		int   guard;
		logic prev;
		logic seen;
		@(negedge sys_clk);
		prev  = motor_1_pwm;
		seen  = 1'b0;
		guard = 0;
		while (!seen) begin
			@(negedge sys_clk);
			seen = !prev && motor_1_pwm;
			prev = motor_1_pwm;
			guard++;
			if (guard > 2 * ESC_PERIOD_US * US_DIV)
				abort_run("No ESC frame start seen on motor_1_pwm");
		end
	endtask

	task automatic check_esc(input int t);
		int hi_cyc [4];
		int guard;
		// Frame after the first rise surely holds the new rates
		wait_esc_rise();
		wait_esc_rise();
		for (int c = 0; c < 4; c++)
			hi_cyc[c] = esc_pins[c] ? 1 : 0;
		guard = 0;
		while (esc_pins != 4'b0000) begin
			@(negedge sys_clk);
			for (int c = 0; c < 4; c++)
				if (esc_pins[c])
					hi_cyc[c]++;
			guard++;
			if (guard > ESC_PERIOD_US * US_DIV)
				abort_run("ESC outputs stayed high for a whole frame");
		end
		for (int c = 0; c < 4; c++)
			check_pulse_us(names[t], c + 1, PULSE_MIN_US + PULSE_STEP_US * exp_rate[t][c],
				(hi_cyc[c] + US_DIV / 2) / US_DIV);
	endtask

	// Bound assertions count their failures
	always @(negedge sys_clk)
		if (u_dut.u_props.assert_fails != 0)
			abort_run("A bound assertion on drone_core failed");

	initial begin
		wait (limit_ns > 0);
		#(limit_ns);
		abort_run("Watchdog timeout, the tests did not finish in time");
	end

	initial begin
		int t;
		int last;
		resetn      = 1'b0;
		rc_pwm      = 4'b0000;
		imu_valid   = 1'b0;
		roll_angle  = '0;
		pitch_angle = '0;
		roll_gyro   = '0;
		pitch_gyro  = '0;
		yaw_gyro    = '0;
		load_tests();
		repeat (8) @(posedge sys_clk);
		resetn <= 1'b1;
		t = 0;
		while (t < n_tests) begin
			// Burst lines share the sticks of the line that opens the group
			last = t;
			while (last + 1 < n_tests && burst[last + 1] == 1)
				last++;
			send_rc_pulses(t);
			run_imu_group(t, last);
			check_esc(last);
			t = last + 1;
		end
		// Late assertion failures may not have been polled yet
		if (u_dut.u_props.assert_fails == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			abort_run("A bound assertion on drone_core failed");
		end
	end

endmodule

// ==== tb/drone_core_properties.sv ====
// Bound into drone_core; failures are counted in assert_fails so the testbench can stop the run
`timescale 1ns/1ns

module drone_core_properties (
	input logic                    sys_clk,
	input logic                    resetn,
	input logic                    imu_valid,
	input logic                    mix_valid,
	input flight_pkg::motor_rate_t motor_1_rate,
	input flight_pkg::motor_rate_t motor_2_rate,
	input flight_pkg::motor_rate_t motor_3_rate,
	input flight_pkg::motor_rate_t motor_4_rate,
	input logic                    motor_1_pwm,
	input logic                    motor_2_pwm,
	input logic                    motor_3_pwm,
	input logic                    motor_4_pwm
);
	import flight_pkg::*;

	int assert_fails = 0;

	// Three-stage pipeline, checked both ways
	a_lat_fwd: assert property (@(posedge sys_clk) disable iff (!resetn)
		imu_valid |-> ##3 mix_valid)
		else begin
			assert_fails++;
			$error("mix_valid missing three cycles after imu_valid");
		end

	a_lat_back: assert property (@(posedge sys_clk) disable iff (!resetn)
		mix_valid |-> $past(imu_valid, 3))
		else begin
			assert_fails++;
			$error("mix_valid without imu_valid three cycles earlier");
		end

	a_range: assert property (@(posedge sys_clk) disable iff (!resetn)
		motor_1_rate <= MOTOR_MAX && motor_2_rate <= MOTOR_MAX &&
		motor_3_rate <= MOTOR_MAX && motor_4_rate <= MOTOR_MAX)
		else begin
			assert_fails++;
			$error("Motor rate above the motor range");
		end

	// Reset is synchronous, so outputs settle one edge later
	a_reset: assert property (@(posedge sys_clk)
		!resetn |=> !mix_valid && !motor_1_pwm && !motor_2_pwm && !motor_3_pwm && !motor_4_pwm)
		else begin
			assert_fails++;
			$error("Outputs not low during reset");
		end

endmodule

// ==== hw/drone_core.sv ====
// Flight datapath top; IMU samples arrive with a one-cycle imu_valid and motor rates follow 3 cycles later
`timescale 1ns/1ns

module drone_core (
	input  logic                    sys_clk,
	input  logic                    resetn,
	input  logic                    throttle_pwm,
	input  logic                    roll_pwm,
	input  logic                    pitch_pwm,
	input  logic                    yaw_pwm,
	input  logic                    imu_valid,
	input  flight_pkg::imu_sample_t roll_angle,
	input  flight_pkg::imu_sample_t pitch_angle,
	input  flight_pkg::imu_sample_t roll_gyro,
	input  flight_pkg::imu_sample_t pitch_gyro,
	input  flight_pkg::imu_sample_t yaw_gyro,
	output logic                    motor_1_pwm,
	output logic                    motor_2_pwm,
	output logic                    motor_3_pwm,
	output logic                    motor_4_pwm,
	output logic                    mix_valid,
	output flight_pkg::motor_rate_t motor_1_rate,
	output flight_pkg::motor_rate_t motor_2_rate,
	output flight_pkg::motor_rate_t motor_3_rate,
	output flight_pkg::motor_rate_t motor_4_rate
);
	import flight_pkg::*;
	import rc_pkg::*;

	logic [US_CNT_W-1:0] div_cnt;
	logic                us_tick;
	stick_t              throttle_val;
	stick_t              roll_val;
	stick_t              pitch_val;
	stick_t              yaw_val;
	logic                ctrl_valid;
	stick_t              throttle_cmd;
	rate_cmd_t           roll_cmd;
	rate_cmd_t           pitch_cmd;
	rate_cmd_t           yaw_cmd;

	// One-cycle tick every microsecond
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			div_cnt <= '0;
			us_tick <= 1'b0;
		end else if (div_cnt == US_CNT_W'(US_DIV - 1)) begin
			div_cnt <= '0;
			us_tick <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			us_tick <= 1'b0;
		end
	end

	// Receiver channels
	rc_pulse_decoder u_dec_throttle (
		.sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
		.pwm_in(throttle_pwm), .value(throttle_val));
	rc_pulse_decoder u_dec_roll (
		.sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
		.pwm_in(roll_pwm), .value(roll_val));
	rc_pulse_decoder u_dec_pitch (
		.sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
		.pwm_in(pitch_pwm), .value(pitch_val));
	rc_pulse_decoder u_dec_yaw (
		.sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
		.pwm_in(yaw_pwm), .value(yaw_val));

	// Angle and rate loops
	attitude_controller u_ctrl (
		.sys_clk(sys_clk), .resetn(resetn), .imu_valid(imu_valid),
		.roll_angle(roll_angle), .pitch_angle(pitch_angle),
		.roll_gyro(roll_gyro), .pitch_gyro(pitch_gyro), .yaw_gyro(yaw_gyro),
		.throttle(throttle_val), .roll_stick(roll_val),
		.pitch_stick(pitch_val), .yaw_stick(yaw_val),
		.ctrl_valid(ctrl_valid), .throttle_cmd(throttle_cmd),
		.roll_cmd(roll_cmd), .pitch_cmd(pitch_cmd), .yaw_cmd(yaw_cmd));

	// Mixer results double as telemetry
	motor_mixer u_mixer (
		.sys_clk(sys_clk), .resetn(resetn), .ctrl_valid(ctrl_valid),
		.throttle_cmd(throttle_cmd), .roll_cmd(roll_cmd),
		.pitch_cmd(pitch_cmd), .yaw_cmd(yaw_cmd), .mix_valid(mix_valid),
		.motor_1_rate(motor_1_rate), .motor_2_rate(motor_2_rate),
		.motor_3_rate(motor_3_rate), .motor_4_rate(motor_4_rate));

	esc_pwm_generator u_esc (
		.sys_clk(sys_clk), .resetn(resetn), .us_tick(us_tick),
		.motor_1_rate(motor_1_rate), .motor_2_rate(motor_2_rate),
		.motor_3_rate(motor_3_rate), .motor_4_rate(motor_4_rate),
		.motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm));

endmodule

// ==== hw/esc_pwm_generator.sv ====
// Four ESC outputs on one 2500 us frame; rates are sampled at frame start so changes show a frame later
`timescale 1ns/1ns

module esc_pwm_generator (
	input  logic                    sys_clk,
	input  logic                    resetn,
	input  logic                    us_tick,
	input  flight_pkg::motor_rate_t motor_1_rate,
	input  flight_pkg::motor_rate_t motor_2_rate,
	input  flight_pkg::motor_rate_t motor_3_rate,
	input  flight_pkg::motor_rate_t motor_4_rate,
	output logic                    motor_1_pwm,
	output logic                    motor_2_pwm,
	output logic                    motor_3_pwm,
	output logic                    motor_4_pwm
);
	import flight_pkg::*;
	import rc_pkg::*;

	logic [FRAME_W-1:0] frame_us;
	logic               frame_end;
	motor_rate_t        rate_in [4];
	logic [FRAME_W-1:0] pulse_len [4];
	logic [3:0]         pwm_q;

	// High time in ticks for one rate
	function automatic logic [FRAME_W-1:0] high_ticks(input motor_rate_t r);
		return FRAME_W'(PULSE_MIN_US) + FRAME_W'(r) * FRAME_W'(PULSE_STEP_US);
	endfunction

	assign rate_in[0] = motor_1_rate;
	assign rate_in[1] = motor_2_rate;
	assign rate_in[2] = motor_3_rate;
	assign rate_in[3] = motor_4_rate;

	// Last tick of the frame
	assign frame_end = us_tick && frame_us == FRAME_W'(ESC_PERIOD_US - 1);

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			frame_us <= '0;
			pwm_q    <= '0;
			// Zero length keeps the pins low until the first frame
			for (int i = 0; i < 4; i++)
				pulse_len[i] <= '0;
		end else begin
			if (frame_end)
				frame_us <= '0;
			else if (us_tick)
				frame_us <= frame_us + 1'b1;
			for (int i = 0; i < 4; i++) begin
				if (frame_end)
					pulse_len[i] <= high_ticks(rate_in[i]);
				pwm_q[i] <= frame_us < pulse_len[i];
			end
		end
	end

	assign motor_1_pwm = pwm_q[0];
	assign motor_2_pwm = pwm_q[1];
	assign motor_3_pwm = pwm_q[2];
	assign motor_4_pwm = pwm_q[3];

endmodule

// ==== hw/motor_mixer.sv ====
// X-frame mixer with motor 1 front right; outputs hold between strobes and read zero below arm throttle
`timescale 1ns/1ns

module motor_mixer (
	input  logic                    sys_clk,
	input  logic                    resetn,
	input  logic                    ctrl_valid,
	input  flight_pkg::stick_t      throttle_cmd,
	input  flight_pkg::rate_cmd_t   roll_cmd,
	input  flight_pkg::rate_cmd_t   pitch_cmd,
	input  flight_pkg::rate_cmd_t   yaw_cmd,
	output logic                    mix_valid,
	output flight_pkg::motor_rate_t motor_1_rate,
	output flight_pkg::motor_rate_t motor_2_rate,
	output flight_pkg::motor_rate_t motor_3_rate,
	output flight_pkg::motor_rate_t motor_4_rate
);
	import flight_pkg::*;

	logic signed [MIX_W-1:0] thr_w;
	logic signed [MIX_W-1:0] roll_w;
	logic signed [MIX_W-1:0] pitch_w;
	logic signed [MIX_W-1:0] yaw_w;
	logic signed [MIX_W-1:0] sum_1;
	logic signed [MIX_W-1:0] sum_2;
	logic signed [MIX_W-1:0] sum_3;
	logic signed [MIX_W-1:0] sum_4;
	logic                    armed;

	// Saturate into the motor range
	function automatic motor_rate_t clamp(input logic signed [MIX_W-1:0] s);
		if (s < 0)
			return '0;
		else if (s > MIX_W'(MOTOR_MAX))
			return motor_rate_t'(MOTOR_MAX);
		else
			return s[MOTOR_W-1:0];
	endfunction

	// Sign-extend everything to the mix width
	assign thr_w   = $signed({{(MIX_W-STICK_W){1'b0}}, throttle_cmd});
	assign roll_w  = MIX_W'(roll_cmd);
	assign pitch_w = MIX_W'(pitch_cmd);
	assign yaw_w   = MIX_W'(yaw_cmd);

	// Diagonal pairs share yaw sign
	assign sum_1 = thr_w + pitch_w + roll_w - yaw_w;
	assign sum_2 = thr_w + pitch_w - roll_w + yaw_w;
	assign sum_3 = thr_w - pitch_w - roll_w - yaw_w;
	assign sum_4 = thr_w - pitch_w + roll_w + yaw_w;

	assign armed = throttle_cmd >= stick_t'(ARM_MIN);

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			mix_valid    <= 1'b0;
			motor_1_rate <= '0;
			motor_2_rate <= '0;
			motor_3_rate <= '0;
			motor_4_rate <= '0;
		end else begin
			mix_valid <= ctrl_valid;
			if (ctrl_valid) begin
				motor_1_rate <= armed ? clamp(sum_1) : '0;
				motor_2_rate <= armed ? clamp(sum_2) : '0;
				motor_3_rate <= armed ? clamp(sum_3) : '0;
				motor_4_rate <= armed ? clamp(sum_4) : '0;
			end
		end
	end

endmodule

// ==== control/attitude_controller.sv ====
// Proportional angle then rate loop; samples are taken only on imu_valid, no integral or derivative terms
`timescale 1ns/1ns

module attitude_controller (
	input  logic                    sys_clk,
	input  logic                    resetn,
	input  logic                    imu_valid,
	input  flight_pkg::imu_sample_t roll_angle,
	input  flight_pkg::imu_sample_t pitch_angle,
	input  flight_pkg::imu_sample_t roll_gyro,
	input  flight_pkg::imu_sample_t pitch_gyro,
	input  flight_pkg::imu_sample_t yaw_gyro,
	input  flight_pkg::stick_t      throttle,
	input  flight_pkg::stick_t      roll_stick,
	input  flight_pkg::stick_t      pitch_stick,
	input  flight_pkg::stick_t      yaw_stick,
	output logic                    ctrl_valid,
	output flight_pkg::stick_t      throttle_cmd,
	output flight_pkg::rate_cmd_t   roll_cmd,
	output flight_pkg::rate_cmd_t   pitch_cmd,
	output flight_pkg::rate_cmd_t   yaw_cmd
);
	import flight_pkg::*;

	// Stage 1 registers
	logic                     stage1_valid;
	logic signed [CTRL_W-1:0] roll_tgt;
	logic signed [CTRL_W-1:0] pitch_tgt;
	logic signed [CTRL_W-1:0] yaw_tgt;
	imu_sample_t              roll_gyro_q;
	imu_sample_t              pitch_gyro_q;
	imu_sample_t              yaw_gyro_q;
	stick_t                   throttle_q;

	// Signed stick deflection around center
	function automatic logic signed [CTRL_W-1:0] stick_offset(input stick_t s);
		return $signed({{(CTRL_W-STICK_W){1'b0}}, s}) - CTRL_W'(STICK_CENTER);
	endfunction

	// Outer loop
	function automatic logic signed [CTRL_W-1:0] angle_step(input stick_t s,
		input imu_sample_t a);
		return (stick_offset(s) - CTRL_W'(a)) >>> ANGLE_SHIFT;
	endfunction

	// Inner loop, result always fits the command width after the shift
	function automatic rate_cmd_t rate_step(input logic signed [CTRL_W-1:0] tgt,
		input imu_sample_t g);
		logic signed [CTRL_W-1:0] err;
		err = (tgt - CTRL_W'(g)) >>> RATE_SHIFT;
		return err[CMD_W-1:0];
	endfunction

	// Valid strobes
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			stage1_valid <= 1'b0;
			ctrl_valid   <= 1'b0;
		end else begin
			stage1_valid <= imu_valid;
			ctrl_valid   <= stage1_valid;
		end
	end

	// Payload advances only with its strobe
	always_ff @(posedge sys_clk) begin
		if (imu_valid) begin
			roll_tgt     <= angle_step(roll_stick, roll_angle);
			pitch_tgt    <= angle_step(pitch_stick, pitch_angle);
			// No heading hold, yaw stick is the rate target
			yaw_tgt      <= stick_offset(yaw_stick);
			roll_gyro_q  <= roll_gyro;
			pitch_gyro_q <= pitch_gyro;
			yaw_gyro_q   <= yaw_gyro;
			throttle_q   <= throttle;
		end
		if (stage1_valid) begin
			roll_cmd     <= rate_step(roll_tgt, roll_gyro_q);
			pitch_cmd    <= rate_step(pitch_tgt, pitch_gyro_q);
			yaw_cmd      <= rate_step(yaw_tgt, yaw_gyro_q);
			throttle_cmd <= throttle_q;
		end
	end

endmodule

// ==== hw/rc_pulse_decoder.sv ====
// One RC channel; pwm_in may be asynchronous, width is resolved to one us_tick, pulses over 3000 us are dropped
`timescale 1ns/1ns

module rc_pulse_decoder (
	input  logic             sys_clk,
	input  logic             resetn,
	input  logic             us_tick,
	input  logic             pwm_in,
	output flight_pkg::stick_t value
);
	import flight_pkg::*;
	import rc_pkg::*;

	logic pwm_meta;
	logic pwm_sync;
	logic pwm_prev;
	logic fall;
	logic [WIDTH_W-1:0] width_us;
	logic [WIDTH_W-1:0] above_min;
	logic [WIDTH_W-1:0] steps;

	// End of the high phase
	assign fall = pwm_prev & ~pwm_sync;

	// Width to stick steps, only meaningful when width is at least the minimum
	assign above_min = width_us - WIDTH_W'(PULSE_MIN_US);
	assign steps     = above_min / WIDTH_W'(PULSE_STEP_US);

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			pwm_meta <= 1'b0;
			pwm_sync <= 1'b0;
			pwm_prev <= 1'b0;
			width_us <= '0;
			value    <= '0;
		end else begin
			// Two-flop synchronizer then edge detect
			pwm_meta <= pwm_in;
			pwm_sync <= pwm_meta;
			pwm_prev <= pwm_sync;

			// Count ticks while high, saturate just past the glitch limit
			if (!pwm_sync)
				width_us <= '0;
			else if (us_tick && width_us <= WIDTH_W'(PULSE_MAX_US))
				width_us <= width_us + 1'b1;

			// Overlong pulse keeps the old value
			if (fall && width_us <= WIDTH_W'(PULSE_MAX_US)) begin
				if (width_us < WIDTH_W'(PULSE_MIN_US))
					value <= '0;
				else if (steps > WIDTH_W'(MOTOR_MAX))
					value <= stick_t'(MOTOR_MAX);
				else
					value <= steps[STICK_W-1:0];
			end
		end
	end

endmodule

// ==== common/rc_pkg.sv ====
// RC and ESC pulse timing in microseconds; assumes a 38 MHz sys_clk for the microsecond tick
package rc_pkg;

	// sys_clk cycles per microsecond tick
	localparam int US_DIV   = 38;
	localparam int US_CNT_W = $clog2(US_DIV);

	// Pulse width for value 0
	localparam int PULSE_MIN_US  = 1000;
	// Microseconds per value step
	localparam int PULSE_STEP_US = 4;
	// Longer pulses count as glitches
	localparam int PULSE_MAX_US  = 3000;
	// Width counter covers the glitch limit plus one
	localparam int WIDTH_W       = 12;

	// ESC frame length
	localparam int ESC_PERIOD_US = 2500;
	localparam int FRAME_W       = $clog2(ESC_PERIOD_US);

endpackage

// ==== common/flight_pkg.sv ====
// Datapath widths and controller gains; IMU samples are raw signed sensor units, gains are fixed shifts
package flight_pkg;

	// Port widths
	localparam int STICK_W = 8;
	localparam int IMU_W   = 16;
	localparam int CMD_W   = 16;
	localparam int MOTOR_W = 8;

	// Controller intermediate width
	// Holds stick offset minus a full-scale sample without wrap
	localparam int CTRL_W = 18;

	// Mixer sum width
	// Throttle plus three full-scale commands
	localparam int MIX_W = 19;

	typedef logic [STICK_W-1:0] stick_t;
	typedef logic signed [IMU_W-1:0] imu_sample_t;
	typedef logic signed [CMD_W-1:0] rate_cmd_t;
	typedef logic [MOTOR_W-1:0] motor_rate_t;

	// Neutral stick position
	localparam int STICK_CENTER = 125;
	// Top of the motor range, also the stick clamp
	localparam int MOTOR_MAX = 250;
	// Throttle below this keeps all motors off
	localparam int ARM_MIN = 10;

	// Outer angle loop gain of 1/2
	localparam int ANGLE_SHIFT = 1;
	// Inner rate loop gain of 1/4
	localparam int RATE_SHIFT = 2;

endpackage
